//--- source/acc_mem_pkg.sv
`default_nettype none

package acc_mem_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int TAG_W = 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [TAG_W-1:0] tag_t;

  typedef struct packed {
    addr_t addr;
    tag_t  tag;
  } rd_req_t;

  typedef struct packed {
    tag_t  tag;
    data_t data;
  } rd_rsp_t;

  typedef struct packed {
    addr_t addr;
    tag_t  tag;
    data_t data;
  } wr_req_t;

endpackage

`default_nettype wire

//--- source/acc_cfg_pkg.sv
`default_nettype none

package acc_cfg_pkg;

  typedef logic [15:0] qtd_t;

  typedef struct packed {
    acc_mem_pkg::addr_t base;
    qtd_t               count;
    acc_mem_pkg::tag_t  id;
  } queue_conf_t;

  // tag values of the three requesters.
  localparam acc_mem_pkg::tag_t IN_QUEUE_ID = 8'd1;
  localparam acc_mem_pkg::tag_t OUT_QUEUE_ID = 8'd2;
  localparam acc_mem_pkg::tag_t STATUS_QUEUE_ID = 8'd3;

  localparam acc_mem_pkg::addr_t STATUS_ADDR = 32'h0000_f000;

  localparam int FIFO_DEPTH = 4;
  localparam int WORD_BYTES = 4;

endpackage

`default_nettype wire

//--- source/payload_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module payload_fifo #(
  parameter type item_t = logic [31:0],
  parameter int  DEPTH  = 4
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       push_valid,
  output logic       push_ready,
  input  item_t      push_item,
  output logic       pop_valid,
  input  logic       pop_ready,
  output item_t      pop_item,
  output logic [2:0] level
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  item_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push_ready = level < 3'(DEPTH);
  assign pop_valid  = level != 3'd0;
  assign pop_item   = mem[rd_ptr];
  assign do_push    = push_valid && push_ready;
  assign do_pop     = pop_valid && pop_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_next(wr_ptr);
      if (do_pop) rd_ptr <= ptr_next(rd_ptr);
      level <= level + {2'b00, do_push} - {2'b00, do_pop}; // push and pop may share a cycle.
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_item;
  end

endmodule

`default_nettype wire

//--- source/burst_counter.sv
`timescale 1ns/1ps
`default_nettype none

module burst_counter (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              load,
  input  acc_cfg_pkg::qtd_t total,
  input  logic              issue,
  input  logic              complete,
  output acc_cfg_pkg::qtd_t next_index,
  output acc_cfg_pkg::qtd_t outstanding,
  output logic              finished
);

  import acc_cfg_pkg::*;

  qtd_t total_q;
  qtd_t completed_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      total_q     <= '0;
      next_index  <= '0;
      completed_q <= '0;
    end else if (load) begin
      total_q     <= total;
      next_index  <= '0;
      completed_q <= '0;
    end else begin
      if (issue) next_index <= next_index + 1'b1;
      if (complete) completed_q <= completed_q + 1'b1;
    end
  end

  assign outstanding = next_index - completed_q;
  assign finished    = completed_q == total_q;

endmodule

`default_nettype wire

//--- source/queue_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module queue_fetch (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     conf_load,
  input  acc_cfg_pkg::queue_conf_t conf,
  input  logic                     run,
  output logic                     rd_req_valid,
  input  logic                     rd_req_ready,
  output acc_mem_pkg::rd_req_t     rd_req,
  input  logic                     rd_rsp_valid,
  input  acc_mem_pkg::rd_rsp_t     rd_rsp,
  output logic                     in_valid,
  input  logic                     in_ready,
  output acc_mem_pkg::data_t       in_data,
  output logic                     finished,
  output logic                     pending
);

  import acc_cfg_pkg::*;
  import acc_mem_pkg::*;

  queue_conf_t conf_q;
  qtd_t        next_index;
  qtd_t        outstanding;
  logic [2:0]  level;
  logic        issue;
  logic        complete;
  logic        all_issued;
  logic        rsp_match;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      conf_q <= '0;
    end else if (conf_load) begin
      conf_q <= conf;
    end
  end

  // outstanding covers words in flight and words still buffered, so it is the used credit.
  assign all_issued   = next_index == conf_q.count;
  assign rd_req_valid = run && !all_issued && (outstanding < qtd_t'(FIFO_DEPTH));
  assign rd_req.addr  = conf_q.base + addr_t'(next_index) * addr_t'(WORD_BYTES);
  assign rd_req.tag   = conf_q.id;
  assign issue        = rd_req_valid && rd_req_ready;

  assign rsp_match = rd_rsp_valid && (rd_rsp.tag == conf_q.id); // other tags belong elsewhere.
  assign complete  = in_valid && in_ready;
  assign pending   = outstanding != qtd_t'(level);

  burst_counter i_burst_counter (
    .clk        (clk),
    .arst_n     (arst_n),
    .load       (conf_load),
    .total      (conf.count),
    .issue      (issue),
    .complete   (complete),
    .next_index (next_index),
    .outstanding(outstanding),
    .finished   (finished)
  );

  payload_fifo #(
    .item_t(data_t),
    .DEPTH (FIFO_DEPTH)
  ) i_read_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .push_valid(rsp_match),
    .push_ready(),
    .push_item (rd_rsp.data),
    .pop_valid (in_valid),
    .pop_ready (in_ready),
    .pop_item  (in_data),
    .level     (level)
  );

endmodule

`default_nettype wire

//--- source/queue_store.sv
`timescale 1ns/1ps
`default_nettype none

module queue_store (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     conf_load,
  input  acc_cfg_pkg::queue_conf_t conf,
  input  logic                     run,
  input  logic                     out_valid,
  output logic                     out_ready,
  input  acc_mem_pkg::data_t       out_data,
  output logic                     wr_req_valid,
  input  logic                     wr_req_ready,
  output acc_mem_pkg::wr_req_t     wr_req,
  input  logic                     wr_ack_valid,
  input  acc_mem_pkg::tag_t        wr_ack_tag,
  output acc_cfg_pkg::qtd_t        acked_count,
  output logic                     finished,
  output logic                     pending
);

  import acc_cfg_pkg::*;
  import acc_mem_pkg::*;

  queue_conf_t conf_q;
  qtd_t        next_index;
  qtd_t        outstanding;
  wr_req_t     req_item;
  logic        issue;
  logic        complete;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      conf_q <= '0;
    end else if (conf_load) begin
      conf_q <= conf;
    end
  end

  assign req_item.addr = conf_q.base + addr_t'(next_index) * addr_t'(WORD_BYTES);
  assign req_item.tag  = conf_q.id;
  assign req_item.data = out_data;

  // results already in the kernel still drain after run drops.
  assign issue       = out_valid && out_ready && (run || outstanding != '0 || next_index != '0);
  assign complete    = wr_ack_valid && (wr_ack_tag == conf_q.id);
  assign pending     = outstanding != '0;
  assign acked_count = next_index - outstanding;

  burst_counter i_burst_counter (
    .clk        (clk),
    .arst_n     (arst_n),
    .load       (conf_load),
    .total      (conf.count),
    .issue      (issue),
    .complete   (complete),
    .next_index (next_index),
    .outstanding(outstanding),
    .finished   (finished)
  );

  payload_fifo #(
    .item_t(wr_req_t),
    .DEPTH (FIFO_DEPTH)
  ) i_write_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .push_valid(out_valid),
    .push_ready(out_ready),
    .push_item (req_item),
    .pop_valid (wr_req_valid),
    .pop_ready (wr_req_ready),
    .pop_item  (wr_req),
    .level     ()
  );

endmodule

`default_nettype wire

//--- source/acc_kernel.sv
`timescale 1ns/1ps
`default_nettype none

module acc_kernel (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               in_valid,
  output logic               in_ready,
  input  acc_mem_pkg::data_t in_data,
  output logic               out_valid,
  input  logic               out_ready,
  output acc_mem_pkg::data_t out_data,
  output logic               busy
);

  import acc_mem_pkg::*;

  data_t data_q;
  logic  full_q;

  assign in_ready  = !full_q || out_ready; // the register frees up in the cycle it drains.
  assign out_valid = full_q;
  assign out_data  = data_q;
  assign busy      = full_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      full_q <= 1'b0;
    end else if (in_ready) begin
      full_q <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) data_q <= in_data + 1'b1;
  end

endmodule

`default_nettype wire

//--- source/run_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module run_fsm (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 start,
  input  logic                 fetch_finished,
  input  logic                 store_finished,
  input  logic                 fetch_pending,
  input  logic                 store_pending,
  input  logic                 kernel_busy,
  output logic                 run,
  output logic                 status_req_valid,
  input  logic                 status_req_ready,
  output acc_mem_pkg::wr_req_t status_req,
  input  acc_cfg_pkg::qtd_t    status_count,
  output logic                 done
);

  import acc_cfg_pkg::*;
  import acc_mem_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_RUN,
    S_DRAIN,
    S_STATUS,
    S_REPORT
  } state_t;

  state_t state;
  state_t state_next;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= S_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      S_IDLE:   if (start) state_next = S_RUN;
      S_RUN:    if (fetch_finished && store_finished) state_next = S_DRAIN;
      S_DRAIN: begin
        if (!fetch_pending && !store_pending && !kernel_busy) state_next = S_STATUS;
      end
      S_STATUS: if (status_req_ready) state_next = S_REPORT; // held until the port takes it.
      S_REPORT: state_next = S_IDLE;
      default:  state_next = S_IDLE;
    endcase
  end

  assign run              = state == S_RUN;
  assign status_req_valid = state == S_STATUS;
  assign done             = state == S_REPORT;

  assign status_req.addr = STATUS_ADDR;
  assign status_req.tag  = STATUS_QUEUE_ID;
  assign status_req.data = data_t'(status_count);

endmodule

`default_nettype wire

//--- source/acc_top.sv
`timescale 1ns/1ps
`default_nettype none

module acc_top (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     start,
  input  logic [1:0]               conf_valid,
  input  acc_cfg_pkg::queue_conf_t conf,
  output logic                     rd_req_valid,
  input  logic                     rd_req_ready,
  output acc_mem_pkg::rd_req_t     rd_req,
  input  logic                     rd_rsp_valid,
  input  acc_mem_pkg::rd_rsp_t     rd_rsp,
  output logic                     wr_req_valid,
  input  logic                     wr_req_ready,
  output acc_mem_pkg::wr_req_t     wr_req,
  output logic                     status_req_valid,
  input  logic                     status_req_ready,
  output acc_mem_pkg::wr_req_t     status_req,
  input  logic                     wr_ack_valid,
  input  acc_mem_pkg::tag_t        wr_ack_tag,
  output logic                     done
);

  import acc_cfg_pkg::*;
  import acc_mem_pkg::*;

  logic        rst_n;
  logic        start_q;
  logic [1:0]  conf_valid_q;
  queue_conf_t conf_q;
  logic        rd_rsp_valid_q;
  rd_rsp_t     rd_rsp_q;
  logic        wr_ack_valid_q;
  tag_t        wr_ack_tag_q;
  logic        in_valid;
  logic        in_ready;
  data_t       in_data;
  logic        out_valid;
  logic        out_ready;
  data_t       out_data;
  logic        fetch_finished;
  logic        fetch_pending;
  logic        store_finished;
  logic        store_pending;
  logic        kernel_busy;
  logic        run;
  qtd_t        acked_count;

  // release is taken through one flop so the core leaves reset on a clock edge.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rst_n <= 1'b0;
    end else begin
      rst_n <= 1'b1;
    end
  end

  // the ready inputs stay direct, so a transfer is the cycle both sides are high at the ports.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      start_q        <= 1'b0;
      conf_valid_q   <= '0;
      rd_rsp_valid_q <= 1'b0;
      wr_ack_valid_q <= 1'b0;
    end else begin
      start_q        <= start;
      conf_valid_q   <= conf_valid;
      rd_rsp_valid_q <= rd_rsp_valid;
      wr_ack_valid_q <= wr_ack_valid;
    end
  end

  always_ff @(posedge clk) begin
    conf_q       <= conf;
    rd_rsp_q     <= rd_rsp;
    wr_ack_tag_q <= wr_ack_tag;
  end

  queue_fetch i_queue_fetch (
    .clk         (clk),
    .arst_n      (rst_n),
    .conf_load   (conf_valid_q[0]),
    .conf        (conf_q),
    .run         (run),
    .rd_req_valid(rd_req_valid),
    .rd_req_ready(rd_req_ready),
    .rd_req      (rd_req),
    .rd_rsp_valid(rd_rsp_valid_q),
    .rd_rsp      (rd_rsp_q),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_data     (in_data),
    .finished    (fetch_finished),
    .pending     (fetch_pending)
  );

  acc_kernel i_acc_kernel (
    .clk      (clk),
    .arst_n   (rst_n),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_data  (in_data),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_data (out_data),
    .busy     (kernel_busy)
  );

  queue_store i_queue_store (
    .clk         (clk),
    .arst_n      (rst_n),
    .conf_load   (conf_valid_q[1]),
    .conf        (conf_q),
    .run         (run),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_data    (out_data),
    .wr_req_valid(wr_req_valid),
    .wr_req_ready(wr_req_ready),
    .wr_req      (wr_req),
    .wr_ack_valid(wr_ack_valid_q),
    .wr_ack_tag  (wr_ack_tag_q),
    .acked_count (acked_count),
    .finished    (store_finished),
    .pending     (store_pending)
  );

  run_fsm i_run_fsm (
    .clk             (clk),
    .arst_n          (rst_n),
    .start           (start_q),
    .fetch_finished  (fetch_finished),
    .store_finished  (store_finished),
    .fetch_pending   (fetch_pending),
    .store_pending   (store_pending),
    .kernel_busy     (kernel_busy),
    .run             (run),
    .status_req_valid(status_req_valid),
    .status_req_ready(status_req_ready),
    .status_req      (status_req),
    .status_count    (acked_count),
    .done            (done)
  );

endmodule

`default_nettype wire

//--- verif/acc_chk.sv
`timescale 1ns/1ps
`default_nettype none

module acc_chk (
  input logic                 clk,
  input logic                 arst_n,
  input logic                 rd_req_valid,
  input logic                 rd_req_ready,
  input acc_mem_pkg::rd_req_t rd_req,
  input logic                 wr_req_valid,
  input logic                 wr_req_ready,
  input acc_mem_pkg::wr_req_t wr_req,
  input logic                 status_req_valid,
  input logic                 status_req_ready,
  input acc_mem_pkg::wr_req_t status_req,
  input logic                 done
);

  int   fail_count = 0;
  logic quiet;

  assign quiet = !(rd_req_valid || wr_req_valid || status_req_valid || done);

  a_reset_quiet: assert property (@(posedge clk) (!arst_n || $rose(arst_n)) |-> quiet)
    else begin
      fail_count++;
      $error("a request or done was active during reset or right after its release");
    end

  // a request that waits on ready keeps its payload.
  a_rd_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
    rd_req_valid && !rd_req_ready |=> rd_req_valid && $stable(rd_req))
    else begin
      fail_count++;
      $error("read request changed or dropped before it was accepted");
    end

  a_wr_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
    wr_req_valid && !wr_req_ready |=> wr_req_valid && $stable(wr_req))
    else begin
      fail_count++;
      $error("write request changed or dropped before it was accepted");
    end

  a_status_hold: assert property (@(posedge clk) disable iff (!arst_n)
    status_req_valid && !status_req_ready |=> status_req_valid && $stable(status_req))
    else begin
      fail_count++;
      $error("status request changed or dropped before it was accepted");
    end

  a_done_after_status: assert property (@(posedge clk) disable iff (!arst_n)
    status_req_valid && status_req_ready |=> done)
    else begin
      fail_count++;
      $error("done did not follow the accepted status write");
    end

  a_done_needs_status: assert property (@(posedge clk) disable iff (!arst_n)
    done |-> $past(status_req_valid && status_req_ready))
    else begin
      fail_count++;
      $error("done rose without a status write accepted in the cycle before");
    end

  a_done_single: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
    else begin
      fail_count++;
      $error("done stayed high for more than one cycle");
    end

endmodule

bind acc_top acc_chk i_acc_chk (
  .clk             (clk),
  .arst_n          (arst_n),
  .rd_req_valid    (rd_req_valid),
  .rd_req_ready    (rd_req_ready),
  .rd_req          (rd_req),
  .wr_req_valid    (wr_req_valid),
  .wr_req_ready    (wr_req_ready),
  .wr_req          (wr_req),
  .status_req_valid(status_req_valid),
  .status_req_ready(status_req_ready),
  .status_req      (status_req),
  .done            (done)
);

`default_nettype wire

//--- verif/acc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module acc_tb;

  import acc_cfg_pkg::*;
  import acc_mem_pkg::*;

  localparam logic [15:0] LFSR_SEED = 16'd17893;
  localparam int WORDS_TOTAL = 1 + 5 + 12;
  localparam int WATCHDOG_CYCLES = 200 * WORDS_TOTAL + 500;

  logic        clk;
  logic        arst_n;
  logic        start;
  logic [1:0]  conf_valid;
  queue_conf_t conf;
  logic        rd_req_valid;
  logic        rd_req_ready;
  rd_req_t     rd_req;
  logic        rd_rsp_valid;
  rd_rsp_t     rd_rsp;
  logic        wr_req_valid;
  logic        wr_req_ready;
  wr_req_t     wr_req;
  logic        status_req_valid;
  logic        status_req_ready;
  wr_req_t     status_req;
  logic        wr_ack_valid;
  tag_t        wr_ack_tag;
  logic        done;

  logic [15:0] lfsr;
  rd_rsp_t     rsp_queue[$];
  int          rsp_due[$];
  tag_t        ack_queue[$];
  int          ack_due[$];
  int          cycle;
  string       test_name;
  addr_t       in_base;
  addr_t       out_base;
  int          word_count;
  int          reads_seen;
  int          writes_seen;
  int          acks_sent;
  int          status_seen;
  int          done_seen;

  acc_top i_acc_top (
    .clk             (clk),
    .arst_n          (arst_n),
    .start           (start),
    .conf_valid      (conf_valid),
    .conf            (conf),
    .rd_req_valid    (rd_req_valid),
    .rd_req_ready    (rd_req_ready),
    .rd_req          (rd_req),
    .rd_rsp_valid    (rd_rsp_valid),
    .rd_rsp          (rd_rsp),
    .wr_req_valid    (wr_req_valid),
    .wr_req_ready    (wr_req_ready),
    .wr_req          (wr_req),
    .status_req_valid(status_req_valid),
    .status_req_ready(status_req_ready),
    .status_req      (status_req),
    .wr_ack_valid    (wr_ack_valid),
    .wr_ack_tag      (wr_ack_tag),
    .done            (done)
  );

  always #5 clk = ~clk;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      value = (value << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1, "run stopped at cycle %0d", cycle);
  endtask

  task automatic fail_value(input string what, input logic [63:0] expected,
                            input logic [63:0] actual);
    $display("ERROR %s: %s expected %0h actual %0h", test_name, what, expected, actual);
    abort_run();
  endtask

  task automatic fail_plain(input string why);
    $display("ERROR %s: %s", test_name, why);
    abort_run();
  endtask

  // memory model with random latency and back-pressure.
  always @(posedge clk) begin : mem_model
    int      delay;
    int      pick;
    rd_rsp_t rsp;
    addr_t   exp_addr;
    data_t   exp_data;
    cycle++;
    if (rd_req_valid && rd_req_ready) begin
      exp_addr = in_base + addr_t'(WORD_BYTES * reads_seen);
      assert (rd_req.addr == exp_addr) else fail_value("read address", exp_addr, rd_req.addr);
      assert (rd_req.tag == IN_QUEUE_ID) else fail_value("read tag", IN_QUEUE_ID, rd_req.tag);
      draw_bits(2, delay);
      rsp.tag  = rd_req.tag;
      rsp.data = rd_req.addr * 32'd3;
      rsp_queue.push_back(rsp);
      rsp_due.push_back(cycle + 1 + delay);
      reads_seen++;
      assert (reads_seen <= word_count) else fail_value("read count", word_count, reads_seen);
      assert (rsp_queue.size() <= FIFO_DEPTH)
        else fail_value("outstanding reads", FIFO_DEPTH, rsp_queue.size());
    end
    if (rsp_queue.size() != 0 && rsp_due[0] <= cycle) begin
      rd_rsp_valid <= 1'b1;
      rd_rsp       <= rsp_queue.pop_front();
      void'(rsp_due.pop_front());
    end else begin
      rd_rsp_valid <= 1'b0;
    end
    if (wr_req_valid && wr_req_ready) begin
      exp_addr = out_base + addr_t'(WORD_BYTES * writes_seen);
      exp_data = (in_base + addr_t'(WORD_BYTES * writes_seen)) * 32'd3 + 32'd1;
      assert (wr_req.addr == exp_addr) else fail_value("write address", exp_addr, wr_req.addr);
      assert (wr_req.tag == OUT_QUEUE_ID) else fail_value("write tag", OUT_QUEUE_ID, wr_req.tag);
      assert (wr_req.data == exp_data) else fail_value("write data", exp_data, wr_req.data);
      draw_bits(2, delay);
      ack_queue.push_back(wr_req.tag);
      ack_due.push_back(cycle + 1 + delay % 3);
      writes_seen++;
      assert (writes_seen <= word_count) else fail_value("write count", word_count, writes_seen);
    end
    // an ack driven in this edge has not reached the DUT yet.
    if (status_req_valid) begin
      assert (acks_sent == word_count && ack_queue.size() == 0)
        else fail_plain("status write was issued before the last write acknowledge");
      if (status_req_ready) begin
        assert (status_req.addr == STATUS_ADDR)
          else fail_value("status address", STATUS_ADDR, status_req.addr);
        assert (status_req.tag == STATUS_QUEUE_ID)
          else fail_value("status tag", STATUS_QUEUE_ID, status_req.tag);
        assert (status_req.data == data_t'(word_count))
          else fail_value("status data", word_count, status_req.data);
        status_seen++;
      end
    end
    if (ack_queue.size() != 0 && ack_due[0] <= cycle) begin
      wr_ack_valid <= 1'b1;
      wr_ack_tag   <= ack_queue.pop_front();
      void'(ack_due.pop_front());
      acks_sent++;
    end else begin
      wr_ack_valid <= 1'b0;
    end
    if (done) begin
      done_seen++;
      assert (status_seen == 1) else fail_value("status writes before done", 1, status_seen);
    end
    draw_bits(2, pick);
    wr_req_ready <= pick != 0;
    draw_bits(2, pick);
    status_req_ready <= pick != 0;
    draw_bits(3, pick);
    rd_req_ready <= pick != 0; // dropped once in eight cycles.
  end

  always @(posedge clk) begin
    if (i_acc_top.i_acc_chk.fail_count != 0) begin
      $display("ERROR %s: an assertion in the bound checker failed", test_name);
      abort_run();
    end
  end

  task automatic run_test(input string name, input addr_t in_addr, input addr_t out_addr,
                          input int count);
    queue_conf_t in_conf;
    queue_conf_t out_conf;
    test_name     = name;
    in_base       = in_addr;
    out_base      = out_addr;
    word_count    = count;
    reads_seen    = 0;
    writes_seen   = 0;
    acks_sent     = 0;
    status_seen   = 0;
    done_seen     = 0;
    in_conf.base  = in_addr;
    in_conf.count = qtd_t'(count);
    in_conf.id    = IN_QUEUE_ID;
    out_conf.base  = out_addr;
    out_conf.count = qtd_t'(count);
    out_conf.id    = OUT_QUEUE_ID;
    @(posedge clk);
    conf       <= in_conf;
    conf_valid <= 2'b01;
    @(posedge clk);
    conf       <= out_conf;
    conf_valid <= 2'b10;
    @(posedge clk);
    conf_valid <= 2'b00;
    start      <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    while (done_seen == 0) @(posedge clk);
    repeat (8) @(posedge clk); // a second done would show up here.
    assert (reads_seen == count) else fail_value("reads per run", count, reads_seen);
    assert (writes_seen == count) else fail_value("writes per run", count, writes_seen);
    assert (status_seen == 1) else fail_value("status writes per run", 1, status_seen);
    assert (done_seen == 1) else fail_value("done pulses per run", 1, done_seen);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("ERROR %s: watchdog expired after %0d cycles", test_name, WATCHDOG_CYCLES);
    abort_run();
  end

  initial begin
    clk              = 1'b0;
    arst_n           = 1'b0;
    start            = 1'b0;
    conf_valid       = 2'b00;
    conf             = '0;
    rd_req_ready     = 1'b0;
    rd_rsp_valid     = 1'b0;
    rd_rsp           = '0;
    wr_req_ready     = 1'b0;
    status_req_ready = 1'b0;
    wr_ack_valid     = 1'b0;
    wr_ack_tag       = '0;
    lfsr             = LFSR_SEED;
    cycle            = 0;
    test_name        = "reset";
    word_count       = 0;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    repeat (3) @(posedge clk);
    run_test("single_word", 32'h0000_1000, 32'h0000_8000, 1);
    run_test("five_words", 32'h0000_2040, 32'h0000_9000, 5);
    run_test("twelve_words", 32'h0000_3100, 32'h0000_a000, 12);
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
source/acc_mem_pkg.sv
source/acc_cfg_pkg.sv
source/payload_fifo.sv
source/burst_counter.sv
source/queue_fetch.sv
source/queue_store.sv
source/acc_kernel.sv
source/run_fsm.sv
source/acc_top.sv
verif/acc_chk.sv
verif/acc_tb.sv

//--- Bender.yml
package:
  name: acc_shell

sources:
  - source/acc_mem_pkg.sv
  - source/acc_cfg_pkg.sv
  - source/payload_fifo.sv
  - source/burst_counter.sv
  - source/queue_fetch.sv
  - source/queue_store.sv
  - source/acc_kernel.sv
  - source/run_fsm.sv
  - source/acc_top.sv
  - target: test
    files:
      - verif/acc_chk.sv
      - verif/acc_tb.sv
